// File: compile.f
logic/rgmii_rx_pkg.sv
logic/rgmii_input_stage.sv
logic/rgmii_frame_sync.sv
logic/crc32_accumulator.sv
logic/rx_byte_fifo.sv
logic/rgmii_rx_top.sv
tests/rgmii_rx_checker.sv
tests/rgmii_rx_tb.sv

// File: tests/rgmii_rx_tb.sv
module rgmii_rx_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import rgmii_rx_pkg::*;

    localparam int FIFO_DEPTH  = 16;
    localparam int WAIT_LIMIT  = 400;
    localparam int KEEP_ALL    = 1 << 20;
    localparam int GAP_CYCLES  = 12;

    logic         clock;
    logic         reset_n;
    lane_t        rx_lane;
    link_status_t link_status;
    rx_beat_t     m_beat;
    logic         m_valid;
    logic         m_ready;
    count_t       dropped_count;

    rx_beat_t     expected_q[$];
    rx_byte_t     body_q[$];
    rx_byte_t     status_byte;
    rx_byte_t     status_codes [4] = '{8'h03, 8'hF5, 8'h00, 8'h0D};
    int           ready_mode;
    int           error_count;
    int           check_count;
    int           tests_run;
    int           tests_failed;
    int           errors_at_start;
    int           assertion_failures;

    always #5 clock = ~clock;

    rgmii_rx_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut (
        .clock         (clock),
        .reset_n       (reset_n),
        .rx_lane       (rx_lane),
        .link_status   (link_status),
        .m_beat        (m_beat),
        .m_valid       (m_valid),
        .m_ready       (m_ready),
        .dropped_count (dropped_count)
    );

    bind rgmii_rx_top rgmii_rx_checker output_checker (
        .clock         (clock),
        .reset_n       (reset_n),
        .m_beat        (m_beat),
        .m_valid       (m_valid),
        .m_ready       (m_ready),
        .dropped_count (dropped_count)
    );

    ////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////

    // Bit-serial Ethernet CRC, LSB first, final value inverted
    function automatic crc_t frame_crc(input rx_byte_t bytes[$], input int length);
        crc_t crc;
        logic feedback;
        crc = 32'hFFFFFFFF;
        for (int i = 0; i < length; i++) begin
            for (int b = 0; b < 8; b++) begin
                feedback = crc[0] ^ bytes[i][b];
                crc      = crc >> 1;
                if (feedback) begin
                    crc = crc ^ 32'hEDB88320;
                end
            end
        end
        return ~crc;
    endfunction

    // Every byte after the SFD, FCS included, up to keep beats
    function automatic void expect_frame(input rx_byte_t body[$], input logic er_driven,
                                         input int keep);
        int       length;
        crc_t     received_fcs;
        logic     fcs_bad;
        rx_beat_t beat;
        length       = body.size();
        received_fcs = {body[length-1], body[length-2], body[length-3], body[length-4]};
        fcs_bad      = (received_fcs != frame_crc(body, length - 4));
        for (int i = 0; i < length && i < keep; i++) begin
            beat.data  = body[i];
            beat.first = (i == 0);
            beat.last  = (i == length - 1);
            beat.error = beat.last && (fcs_bad || er_driven);
            expected_q.push_back(beat);
        end
    endfunction

    function automatic link_status_t decode_status(input rx_byte_t code);
        link_status_t status;
        status.link_up     = code[0];
        status.speed       = code[2:1];
        status.full_duplex = code[3];
        return status;
    endfunction

    function automatic logic pick_ready();
        case (ready_mode)
            1:       return ($urandom % 4) != 0;
            2:       return 1'b0;
            default: return 1'b1;
        endcase
    endfunction

    ////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////

    task automatic drive_lane(input rx_byte_t data, input logic dv, input logic er);
        @(negedge clock);
        rx_lane.data = data;
        rx_lane.dv   = dv;
        rx_lane.er   = er;
        m_ready      = pick_ready();
    endtask

    // Idle cycles carry the current in-band status
    task automatic idle_cycles(input int count);
        repeat (count) begin
            drive_lane(status_byte, 1'b0, 1'b0);
        end
    endtask

    task automatic build_body(input int payload_length);
        crc_t fcs;
        body_q.delete();
        repeat (payload_length) begin
            body_q.push_back(rx_byte_t'($urandom));
        end
        fcs = frame_crc(body_q, payload_length);
        for (int i = 0; i < 4; i++) begin
            body_q.push_back(fcs[8*i +: 8]);
        end
    endtask

    task automatic send_frame(input int preamble_length, input int bad_index,
                              input rx_byte_t sfd, input int er_index);
        for (int i = 0; i < preamble_length; i++) begin
            drive_lane((i == bad_index) ? 8'hA5 : PREAMBLE_BYTE, 1'b1, 1'b0);
        end
        drive_lane(sfd, 1'b1, 1'b0);
        for (int i = 0; i < body_q.size(); i++) begin
            drive_lane(body_q[i], 1'b1, i == er_index);
        end
    endtask

    task automatic send_good_frame(input int payload_length);
        build_body(payload_length);
        expect_frame(body_q, 1'b0, KEEP_ALL);
        send_frame(PREAMBLE_LENGTH, -1, SFD_BYTE, -1);
        idle_cycles(GAP_CYCLES);
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (expected_q.size() != 0 && cycles < WAIT_LIMIT) begin
            idle_cycles(1);
            cycles++;
        end
        assert (expected_q.size() == 0) else begin
            $display("Timeout: %0d expected beats never left the DUT", expected_q.size());
            error_count++;
            expected_q.delete();
        end
    endtask

    task automatic wait_drop_count(input int target);
        int cycles;
        cycles = 0;
        while (dropped_count != count_t'(target) && cycles < WAIT_LIMIT) begin
            idle_cycles(1);
            cycles++;
        end
        assert (dropped_count == count_t'(target)) else begin
            $display("Mismatch dropped_count: expected %h, got %h", count_t'(target),
                     dropped_count);
            error_count++;
        end
    endtask

    task automatic check_status();
        assert (link_status == decode_status(status_byte)) else begin
            $display("Mismatch link_status: expected %h, got %h",
                     decode_status(status_byte), link_status);
            error_count++;
        end
    endtask

    task automatic finish_test(input string name);
        int errors;
        error_count        += dut.output_checker.failures - assertion_failures;
        assertion_failures  = dut.output_checker.failures;
        errors = error_count - errors_at_start;
        tests_run++;
        if (errors == 0) begin
            $display("test %-26s ok", name);
        end
        else begin
            tests_failed++;
            $display("test %-26s failed with %0d errors", name, errors);
        end
        errors_at_start = error_count;
    endtask

    ////////////////////////////////////////////////////
    // Output comparison
    ////////////////////////////////////////////////////

    always @(posedge clock) begin : compare_beats
        rx_beat_t expected;
        if (reset_n && m_valid && m_ready) begin
            assert (expected_q.size() != 0) else begin
                $display("Unexpected beat with data %h on the output stream", m_beat.data);
                error_count++;
            end
            if (expected_q.size() != 0) begin
                expected = expected_q.pop_front();
                check_count++;
                assert (m_beat.data == expected.data) else begin
                    $display("Mismatch m_beat.data: expected %h, got %h",
                             expected.data, m_beat.data);
                    error_count++;
                end
                assert (m_beat.first == expected.first) else begin
                    $display("Mismatch m_beat.first: expected %h, got %h",
                             expected.first, m_beat.first);
                    error_count++;
                end
                assert (m_beat.last == expected.last) else begin
                    $display("Mismatch m_beat.last: expected %h, got %h",
                             expected.last, m_beat.last);
                    error_count++;
                end
                assert (m_beat.error == expected.error) else begin
                    $display("Mismatch m_beat.error: expected %h, got %h",
                             expected.error, m_beat.error);
                    error_count++;
                end
            end
        end
    end

    ////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////

    initial begin
        int target_drops;
        void'($urandom(32'h4251_9358));
        clock              = 1'b0;
        reset_n            = 1'b0;
        status_byte        = 8'h0D;
        rx_lane.data       = status_byte;
        rx_lane.dv         = 1'b0;
        rx_lane.er         = 1'b0;
        m_ready            = 1'b1;
        ready_mode         = 0;
        error_count        = 0;
        check_count        = 0;
        tests_run          = 0;
        tests_failed       = 0;
        errors_at_start    = 0;
        assertion_failures = 0;

        idle_cycles(10);
        reset_n = 1'b1;
        idle_cycles(4);

        for (int f = 0; f < 6; f++) begin
            send_good_frame(8 + $urandom % 56);
        end
        wait_drain();
        finish_test("good frames");

        // Corrupted FCS, then rx_er mid-payload, with clean frames around them
        send_good_frame(20 + $urandom % 20);
        build_body(20 + $urandom % 20);
        body_q[body_q.size() - 2] ^= 8'h5A;
        expect_frame(body_q, 1'b0, KEEP_ALL);
        send_frame(PREAMBLE_LENGTH, -1, SFD_BYTE, -1);
        idle_cycles(GAP_CYCLES);
        send_good_frame(20 + $urandom % 20);
        build_body(20 + $urandom % 20);
        expect_frame(body_q, 1'b1, KEEP_ALL);
        send_frame(PREAMBLE_LENGTH, -1, SFD_BYTE, body_q.size() / 2);
        idle_cycles(GAP_CYCLES);
        send_good_frame(20 + $urandom % 20);
        wait_drain();
        finish_test("fcs and rx_er errors");

        // None of these may reach the output
        build_body(24);
        send_frame(PREAMBLE_LENGTH, 3, SFD_BYTE, -1);
        idle_cycles(GAP_CYCLES);
        build_body(24);
        send_frame(5, -1, SFD_BYTE, -1);
        idle_cycles(GAP_CYCLES);
        build_body(24);
        send_frame(PREAMBLE_LENGTH, -1, 8'hD4, -1);
        idle_cycles(GAP_CYCLES);
        send_good_frame(30);
        wait_drain();
        finish_test("broken preambles");

        ready_mode = 1;
        for (int f = 0; f < 5; f++) begin
            send_good_frame(8 + $urandom % 13);
        end
        wait_drain();
        ready_mode = 0;
        wait_drop_count(0);
        finish_test("random m_ready stalls");

        foreach (status_codes[i]) begin
            status_byte = status_codes[i];
            idle_cycles(2);
            check_status();
            build_body(16 + $urandom % 16);
            expect_frame(body_q, 1'b0, KEEP_ALL);
            send_frame(PREAMBLE_LENGTH, -1, SFD_BYTE, -1);
            // Frame bytes must not disturb the decoded status
            check_status();
            idle_cycles(GAP_CYCLES);
        end
        wait_drain();
        finish_test("in-band link status");

        // Stalled output through a frame longer than the FIFO
        ready_mode = 2;
        build_body(40 + $urandom % 20);
        target_drops = body_q.size() - FIFO_DEPTH;
        expect_frame(body_q, 1'b0, FIFO_DEPTH);
        send_frame(PREAMBLE_LENGTH, -1, SFD_BYTE, -1);
        wait_drop_count(target_drops);
        ready_mode = 0;
        wait_drain();
        wait_drop_count(target_drops);
        finish_test("overflow with m_ready low");

        $display("tests %0d, failed %0d, beats checked %0d, errors %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end
        else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: tests/rgmii_rx_checker.sv
module rgmii_rx_checker (
    input logic                   clock,
    input logic                   reset_n,
    input rgmii_rx_pkg::rx_beat_t m_beat,
    input logic                   m_valid,
    input logic                   m_ready,
    input rgmii_rx_pkg::count_t   dropped_count
);

    timeunit 1ns;
    timeprecision 100ps;

    logic in_frame;
    logic transfer;

    // Failed assertion count
    int   failures = 0;

    assign transfer = m_valid && m_ready;

    // Set between a first beat and its last beat
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            in_frame <= 1'b0;
        end
        else if (transfer) begin
            in_frame <= !m_beat.last;
        end
    end

    ////////////////////////////////////////////////////
    // Output stream rules
    ////////////////////////////////////////////////////

    stable_while_stalled: assert property (
        @(posedge clock) disable iff (!reset_n)
        m_valid && !m_ready |=> m_valid && $stable(m_beat)
    ) else begin
        $error("m_beat changed or m_valid fell while the stream was stalled");
        failures++;
    end

    idle_after_reset: assert property (
        @(posedge clock)
        !reset_n |=> !m_valid && (dropped_count == '0)
    ) else begin
        $error("m_valid or dropped_count not cleared by reset");
        failures++;
    end

    // A frame opens with first and closes with last, never interleaved
    first_opens_frame: assert property (
        @(posedge clock) disable iff (!reset_n)
        transfer |-> (m_beat.first == !in_frame)
    ) else begin
        $error("first and last markers out of order on the output stream");
        failures++;
    end

endmodule

// File: logic/rgmii_rx_top.sv
module rgmii_rx_top #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                       clock,
    input  logic                       reset_n,
    input  rgmii_rx_pkg::lane_t        rx_lane,
    output rgmii_rx_pkg::link_status_t link_status,
    output rgmii_rx_pkg::rx_beat_t     m_beat,
    output logic                       m_valid,
    input  logic                       m_ready,
    output rgmii_rx_pkg::count_t       dropped_count
);

    import rgmii_rx_pkg::*;

    lane_t    lane_q;
    logic     crc_clear;
    logic     crc_enable;
    rx_byte_t crc_byte;
    logic     crc_match;
    rx_beat_t beat;
    logic     beat_write;

    ////////////////////////////////////////////////////
    // Receive pipeline
    ////////////////////////////////////////////////////

    rgmii_input_stage input_stage (
        .clock       (clock),
        .reset_n     (reset_n),
        .rx_lane     (rx_lane),
        .lane_q      (lane_q),
        .link_status (link_status)
    );

    rgmii_frame_sync frame_sync (
        .clock      (clock),
        .reset_n    (reset_n),
        .lane_q     (lane_q),
        .crc_match  (crc_match),
        .crc_clear  (crc_clear),
        .crc_enable (crc_enable),
        .crc_byte   (crc_byte),
        .beat       (beat),
        .beat_write (beat_write)
    );

    crc32_accumulator crc_check (
        .clock      (clock),
        .reset_n    (reset_n),
        .crc_clear  (crc_clear),
        .crc_enable (crc_enable),
        .crc_byte   (crc_byte),
        .crc_match  (crc_match)
    );

    // Output buffer absorbs stream back-pressure
    rx_byte_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) byte_fifo (
        .clock         (clock),
        .reset_n       (reset_n),
        .beat          (beat),
        .beat_write    (beat_write),
        .m_beat        (m_beat),
        .m_valid       (m_valid),
        .m_ready       (m_ready),
        .dropped_count (dropped_count)
    );

endmodule

// File: logic/rx_byte_fifo.sv
module rx_byte_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                   clock,
    input  logic                   reset_n,
    input  rgmii_rx_pkg::rx_beat_t beat,
    input  logic                   beat_write,
    output rgmii_rx_pkg::rx_beat_t m_beat,
    output logic                   m_valid,
    input  logic                   m_ready,
    output rgmii_rx_pkg::count_t   dropped_count
);

    import rgmii_rx_pkg::*;

    localparam int PTR_WIDTH  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int FILL_WIDTH = $clog2(FIFO_DEPTH + 1);

    typedef logic [PTR_WIDTH-1:0]  ptr_t;
    typedef logic [FILL_WIDTH-1:0] fill_t;

    rx_beat_t memory [FIFO_DEPTH];
    ptr_t     write_ptr;
    ptr_t     read_ptr;
    fill_t    fill;
    logic     full;
    logic     push;
    logic     pop;

    // Wraps for depths that are not a power of two
    function automatic ptr_t ptr_advance(input ptr_t ptr);
        return (ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full    = (fill == FILL_WIDTH'(FIFO_DEPTH));
    assign m_valid = (fill != '0);
    assign m_beat  = memory[read_ptr];
    assign push    = beat_write && !full;
    assign pop     = m_valid && m_ready;

    ////////////////////////////////////////////////////
    // Storage and pointers
    ////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (push) begin
            memory[write_ptr] <= beat;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            write_ptr     <= '0;
            read_ptr      <= '0;
            fill          <= '0;
            dropped_count <= '0;
        end
        else begin
            if (push) begin
                write_ptr <= ptr_advance(write_ptr);
            end
            if (pop) begin
                read_ptr <= ptr_advance(read_ptr);
            end
            if (push && !pop) begin
                fill <= fill + 1'b1;
            end
            else if (pop && !push) begin
                fill <= fill - 1'b1;
            end
            // Line cannot stall, so a full FIFO loses the byte
            if (beat_write && full && (dropped_count != '1)) begin
                dropped_count <= dropped_count + 1'b1;
            end
        end
    end

endmodule

// File: logic/crc32_accumulator.sv
module crc32_accumulator (
    input  logic                   clock,
    input  logic                   reset_n,
    input  logic                   crc_clear,
    input  logic                   crc_enable,
    input  rgmii_rx_pkg::rx_byte_t crc_byte,
    output logic                   crc_match
);

    import rgmii_rx_pkg::*;

    // IEEE 802.3 polynomial in reflected form
    localparam crc_t CRC_POLY = 32'hEDB88320;
    localparam crc_t CRC_INIT = 32'hFFFFFFFF;

    crc_t crc_reg;
    crc_t crc_next;

    ////////////////////////////////////////////////////
    // Byte update
    ////////////////////////////////////////////////////

    // LSB first, one shift per bit, eight steps per byte
    function automatic crc_t crc_update(input crc_t crc, input rx_byte_t data);
        crc_t value;
        value = crc ^ {24'h000000, data};
        for (int bit_index = 0; bit_index < 8; bit_index++) begin
            if (value[0]) begin
                value = (value >> 1) ^ CRC_POLY;
            end
            else begin
                value = value >> 1;
            end
        end
        return value;
    endfunction

    assign crc_next = crc_update(crc_reg, crc_byte);

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            crc_reg <= CRC_INIT;
        end
        else if (crc_clear) begin
            crc_reg <= CRC_INIT;
        end
        else if (crc_enable) begin
            crc_reg <= crc_next;
        end
    end

    // Residue holds once the FCS itself has gone through
    assign crc_match = (crc_reg == CRC_RESIDUE);

endmodule

// File: logic/rgmii_frame_sync.sv
module rgmii_frame_sync (
    input  logic                   clock,
    input  logic                   reset_n,
    input  rgmii_rx_pkg::lane_t    lane_q,
    input  logic                   crc_match,
    output logic                   crc_clear,
    output logic                   crc_enable,
    output rgmii_rx_pkg::rx_byte_t crc_byte,
    output rgmii_rx_pkg::rx_beat_t beat,
    output logic                   beat_write
);

    import rgmii_rx_pkg::*;

    localparam int COUNT_WIDTH = $clog2(PREAMBLE_LENGTH + 1);

    sync_state_t            state;
    sync_state_t            next_state;
    logic [COUNT_WIDTH-1:0] preamble_count;
    logic [COUNT_WIDTH-1:0] next_preamble_count;
    rx_byte_t               hold_data;
    logic                   hold_valid;
    logic                   first_pending;
    logic                   sticky_er;
    logic                   closing;
    logic                   is_preamble;
    logic                   is_sfd;
    logic                   sfd_seen;
    logic                   pack_byte;
    logic                   pack_end;

    assign is_preamble = lane_q.dv && (lane_q.data == PREAMBLE_BYTE);
    assign is_sfd      = lane_q.dv && (lane_q.data == SFD_BYTE);
    assign sfd_seen    = (state == SYNC_SFD) && is_sfd;
    assign pack_byte   = (state == SYNC_PACK) && lane_q.dv;
    assign pack_end    = (state == SYNC_PACK) && !lane_q.dv;

    ////////////////////////////////////////////////////
    // Framing state machine
    ////////////////////////////////////////////////////

    always_comb begin
        next_state          = state;
        next_preamble_count = preamble_count;

        case (state)
            SYNC_HUNT: begin
                if (is_preamble) begin
                    next_preamble_count = COUNT_WIDTH'(1);
                    next_state          = SYNC_PREAMBLE;
                end
            end
            SYNC_PREAMBLE: begin
                if (is_preamble) begin
                    next_preamble_count = preamble_count + 1'b1;
                    if (preamble_count == COUNT_WIDTH'(PREAMBLE_LENGTH - 1)) begin
                        next_state = SYNC_SFD;
                    end
                end
                else begin
                    next_state = SYNC_HUNT;
                end
            end
            SYNC_SFD: begin
                next_state = is_sfd ? SYNC_PACK : SYNC_HUNT;
            end
            SYNC_PACK: begin
                if (!lane_q.dv) begin
                    next_state = SYNC_HUNT;
                end
            end
            default: begin
                next_state = SYNC_HUNT;
            end
        endcase
    end

    // closing marks the cycle where the CRC verdict for the held byte is ready
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state          <= SYNC_HUNT;
            preamble_count <= '0;
            crc_clear      <= 1'b0;
            crc_enable     <= 1'b0;
            beat_write     <= 1'b0;
            hold_valid     <= 1'b0;
            first_pending  <= 1'b0;
            sticky_er      <= 1'b0;
            closing        <= 1'b0;
        end
        else begin
            state          <= next_state;
            preamble_count <= next_preamble_count;
            crc_clear      <= sfd_seen;
            crc_enable     <= pack_byte;
            beat_write     <= 1'b0;
            closing        <= 1'b0;

            if (sfd_seen) begin
                hold_valid    <= 1'b0;
                first_pending <= 1'b1;
                sticky_er     <= 1'b0;
            end

            if (pack_byte) begin
                hold_valid <= 1'b1;
                if (lane_q.er) begin
                    sticky_er <= 1'b1;
                end
                if (hold_valid) begin
                    beat_write    <= 1'b1;
                    first_pending <= 1'b0;
                end
            end

            // Empty frames after the SFD produce nothing
            if (pack_end) begin
                closing    <= hold_valid;
                hold_valid <= 1'b0;
            end

            if (closing) begin
                beat_write    <= 1'b1;
                first_pending <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////
    // Byte holding and beat assembly
    ////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        crc_byte <= lane_q.data;

        if (pack_byte) begin
            hold_data  <= lane_q.data;
            beat.data  <= hold_data;
            beat.first <= first_pending;
            beat.last  <= 1'b0;
            beat.error <= 1'b0;
        end

        if (closing) begin
            beat.data  <= hold_data;
            beat.first <= first_pending;
            beat.last  <= 1'b1;
            beat.error <= sticky_er || !crc_match;
        end
    end

endmodule

// File: logic/rgmii_input_stage.sv
module rgmii_input_stage (
    input  logic                       clock,
    input  logic                       reset_n,
    input  rgmii_rx_pkg::lane_t        rx_lane,
    output rgmii_rx_pkg::lane_t        lane_q,
    output rgmii_rx_pkg::link_status_t link_status
);

    logic inter_frame;

    // No data and no error means the PHY sends its status byte
    assign inter_frame = !rx_lane.dv && !rx_lane.er;

    ////////////////////////////////////////////////////
    // Byte lane register
    ////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            lane_q <= '0;
        end
        else begin
            lane_q <= rx_lane;
        end
    end

    ////////////////////////////////////////////////////
    // In-band status decode
    ////////////////////////////////////////////////////

    // Bit 0 link, bits 2:1 speed, bit 3 duplex
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            link_status <= '0;
        end
        else if (inter_frame) begin
            link_status.link_up     <= rx_lane.data[0];
            link_status.speed       <= rx_lane.data[2:1];
            link_status.full_duplex <= rx_lane.data[3];
        end
    end

endmodule

// File: logic/rgmii_rx_pkg.sv
package rgmii_rx_pkg;

    ////////////////////////////////////////////////////
    // Basic widths
    ////////////////////////////////////////////////////

    typedef logic [7:0]  rx_byte_t;
    typedef logic [31:0] crc_t;
    typedef logic [15:0] count_t;

    // Speed code 0/1/2 for 10/100/1000 Mb/s
    typedef logic [1:0]  speed_t;

    ////////////////////////////////////////////////////
    // Structs
    ////////////////////////////////////////////////////

    // One demultiplexed RGMII receive cycle
    typedef struct packed {
        rx_byte_t data;
        logic     dv;
        logic     er;
    } lane_t;

    // In-band status seen between frames
    typedef struct packed {
        logic   link_up;
        speed_t speed;
        logic   full_duplex;
    } link_status_t;

    // Output stream byte
    typedef struct packed {
        rx_byte_t data;
        logic     first;
        logic     last;
        logic     error;
    } rx_beat_t;

    typedef enum logic [1:0] {
        SYNC_HUNT,
        SYNC_PREAMBLE,
        SYNC_SFD,
        SYNC_PACK
    } sync_state_t;

    parameter rx_byte_t PREAMBLE_BYTE   = 8'h55;
    parameter rx_byte_t SFD_BYTE        = 8'hD5;
    parameter int       PREAMBLE_LENGTH = 7;
    // Register value after a clean frame plus FCS, before inversion
    parameter crc_t     CRC_RESIDUE     = 32'hDEBB20E3;

endpackage
